/* design/autotest_defs.svh */
/* widths, depths and timeout limits shared by the self-test harness RTL;
   include wherever one of these macros is needed */
`ifndef AUTOTEST_DEFS_SVH
`define AUTOTEST_DEFS_SVH

// operand and UUT output width
`define AT_OPERAND_W 32

// record index width, also the width of the count byte
`define AT_INDEX_W 8

// operand records held between reader and sequencer
`define AT_FIFO_DEPTH 4

// system clocks per SPI half-period
`define AT_SCLK_DIV 2

// system clocks to wait for end_uut
`define AT_UUT_TIMEOUT 256

`endif

/* design/autotest_pkg.sv */
/* shared types of the self-test harness: operand vectors, record index,
   clock select and the state encodings of the reader and the sequencer */
`include "autotest_defs.svh"

package autotest_pkg;

  typedef logic [`AT_OPERAND_W-1:0] operand_t;
  typedef logic [`AT_INDEX_W-1:0]   rec_index_t;
  typedef logic [1:0]               clk_sel_t;

  // SPI reader
  typedef enum logic [2:0] {
    RD_IDLE,
    RD_COMMAND,
    RD_COUNT,
    RD_BYTES,
    RD_HOLD
  } reader_state_t;

  // UUT sequencer
  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_FETCH,
    SEQ_RESET_HOLD,
    SEQ_RUN,
    SEQ_REPORT,
    SEQ_FINISHED
  } seq_state_t;

endpackage : autotest_pkg

/* design/vec_stream_if.sv */
/* valid/ready stream carrying one operand record between harness blocks;
   src drives the record, dst drives ready */
`timescale 1ns/1ps

interface vec_stream_if;

  // record payload
  autotest_pkg::operand_t   data;
  autotest_pkg::rec_index_t index;
  logic                     last;

  // handshake, transfer when both high at a rising edge
  logic valid;
  logic ready;

  modport src (
    output data,
    output index,
    output last,
    output valid,
    input  ready
  );

  modport dst (
    input  data,
    input  index,
    input  last,
    input  valid,
    output ready
  );

endinterface : vec_stream_if

/* design/spi_vector_reader.sv */
/* SPI mode 0 master that issues a 0x03 read at address 0, takes the record
   count byte and streams each 4-byte operand out as a record */
`timescale 1ns/1ps
`include "autotest_defs.svh"

module spi_vector_reader (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  logic       miso,
  output logic       cs,
  output logic       sclk,
  output logic       mosi,
  output logic       no_records,
  vec_stream_if.src  out
);

  localparam int DIV_W = (`AT_SCLK_DIV > 1) ? $clog2(`AT_SCLK_DIV) : 1;

  autotest_pkg::reader_state_t state;
  logic [DIV_W-1:0]            div_cnt;
  logic [5:0]                  bit_cnt;
  logic [31:0]                 tx_sr;
  autotest_pkg::operand_t      rx_sr;
  autotest_pkg::rec_index_t    rec_total;
  autotest_pkg::rec_index_t    rec_cnt;
  logic shifting;
  logic half_tick;
  logic rise_tick;
  logic fall_tick;
  logic cmd_done;
  logic count_done;
  logic opnd_done;

  // sclk only runs while a byte is on the wire
  assign shifting  = state inside {autotest_pkg::RD_COMMAND, autotest_pkg::RD_COUNT,
                                   autotest_pkg::RD_BYTES};
  assign half_tick = shifting && (div_cnt == DIV_W'(`AT_SCLK_DIV - 1));
  assign rise_tick = half_tick && !sclk;
  assign fall_tick = half_tick && sclk;

  // words end on the falling edge after their last sample
  assign cmd_done   = (state == autotest_pkg::RD_COMMAND) && fall_tick && (bit_cnt == 6'd31);
  assign count_done = (state == autotest_pkg::RD_COUNT) && fall_tick && (bit_cnt == 6'd7);
  assign opnd_done  = (state == autotest_pkg::RD_BYTES) && fall_tick &&
                      (bit_cnt == 6'(`AT_OPERAND_W - 1));

  assign mosi       = tx_sr[31];
  assign no_records = count_done && (rx_sr[7:0] == 8'h00);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= autotest_pkg::RD_IDLE;
      cs        <= 1'b1;
      sclk      <= 1'b0;
      div_cnt   <= '0;
      bit_cnt   <= '0;
      tx_sr     <= '0;
      rec_total <= '0;
      rec_cnt   <= '0;
      out.valid <= 1'b0;
    end else begin
      if (half_tick) begin
        div_cnt <= '0;
        sclk    <= ~sclk;
      end else if (shifting) begin
        div_cnt <= div_cnt + 1'b1;
      end
      // mode 0, next mosi bit goes out on the falling edge
      if (fall_tick) begin
        bit_cnt <= bit_cnt + 1'b1;
        tx_sr   <= tx_sr << 1;
      end

      case (state)
        autotest_pkg::RD_IDLE: begin
          if (start) begin
            cs      <= 1'b0;
            tx_sr   <= {8'h03, 24'h000000};
            bit_cnt <= '0;
            div_cnt <= '0;
            state   <= autotest_pkg::RD_COMMAND;
          end
        end
        autotest_pkg::RD_COMMAND: begin
          if (cmd_done) begin
            bit_cnt <= '0;
            state   <= autotest_pkg::RD_COUNT;
          end
        end
        autotest_pkg::RD_COUNT: begin
          if (count_done) begin
            bit_cnt   <= '0;
            rec_total <= rx_sr[7:0];
            rec_cnt   <= '0;
            if (rx_sr[7:0] == 8'h00) begin
              cs    <= 1'b1;
              state <= autotest_pkg::RD_IDLE;
            end else begin
              state <= autotest_pkg::RD_BYTES;
            end
          end
        end
        autotest_pkg::RD_BYTES: begin
          if (opnd_done) begin
            bit_cnt   <= '0;
            out.valid <= 1'b1;
            state     <= autotest_pkg::RD_HOLD;
          end
        end
        autotest_pkg::RD_HOLD: begin
          // sclk parked low, cs kept low until the record is taken
          if (out.ready) begin
            out.valid <= 1'b0;
            if (out.last) begin
              cs    <= 1'b1;
              state <= autotest_pkg::RD_IDLE;
            end else begin
              rec_cnt <= rec_cnt + 1'b1;
              state   <= autotest_pkg::RD_BYTES;
            end
          end
        end
        default: state <= autotest_pkg::RD_IDLE;
      endcase
    end
  end

  // miso sampled on the rising edge, MSB first
  always_ff @(posedge clk) begin
    if (rise_tick) begin
      rx_sr <= {rx_sr[`AT_OPERAND_W-2:0], miso};
    end
    if (opnd_done) begin
      out.data  <= rx_sr;
      out.index <= rec_cnt;
      out.last  <= (rec_cnt == rec_total - 1'b1);
    end
  end

endmodule : spi_vector_reader

/* design/vector_fifo.sv */
/* circular FIFO holding operand records between the SPI reader and the
   UUT sequencer; push and pop may happen in the same cycle */
`timescale 1ns/1ps
`include "autotest_defs.svh"

module vector_fifo (
  input  logic      clk,
  input  logic      rst_n,
  vec_stream_if.dst in,
  vec_stream_if.src out
);

  localparam int DEPTH = `AT_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  autotest_pkg::operand_t   data_mem  [DEPTH];
  autotest_pkg::rec_index_t index_mem [DEPTH];
  logic                     last_mem  [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic push;
  logic pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // flow control straight from occupancy
  assign in.ready  = (count != CNT_W'(DEPTH));
  assign out.valid = (count != '0);
  assign push      = in.valid && in.ready;
  assign pop       = out.valid && out.ready;

  assign out.data  = data_mem[rd_ptr];
  assign out.index = index_mem[rd_ptr];
  assign out.last  = last_mem[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      data_mem[wr_ptr]  <= in.data;
      index_mem[wr_ptr] <= in.index;
      last_mem[wr_ptr]  <= in.last;
    end
  end

endmodule : vector_fifo

/* design/uut_sequencer.sv */
/* takes one record at a time, applies it to the UUT and pulses its reset,
   then reports the UUT output, error flag or timeout in record order */
`timescale 1ns/1ps
`include "autotest_defs.svh"

module uut_sequencer (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start,
  input  logic                     no_records,
  input  logic                     end_uut,
  input  logic                     err_uut,
  input  autotest_pkg::operand_t   output_from_uut,
  vec_stream_if.dst                in,
  output logic                     rst_uut,
  output autotest_pkg::operand_t   input_to_uut,
  output logic                     result_valid,
  output autotest_pkg::operand_t   result_data,
  output logic                     result_err,
  output logic                     result_timeout,
  output autotest_pkg::rec_index_t result_index,
  output logic                     done
);

  localparam int TMR_W = $clog2(`AT_UUT_TIMEOUT + 1);

  autotest_pkg::seq_state_t state;
  logic end_meta;
  logic end_sync;
  logic end_prev;
  logic err_meta;
  logic err_sync;
  logic end_rise;
  logic timed_out;
  logic run_end;
  logic [1:0]               hold_cnt;
  logic [TMR_W-1:0]         timer;
  autotest_pkg::rec_index_t cur_index;
  logic                     cur_last;

  assign in.ready  = (state == autotest_pkg::SEQ_FETCH);
  assign end_rise  = end_sync && !end_prev;
  assign timed_out = (timer == TMR_W'(`AT_UUT_TIMEOUT - 1));
  assign run_end   = (state == autotest_pkg::SEQ_RUN) && (end_rise || timed_out);

  // UUT flags come from the clk_uut domain
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      end_meta <= 1'b0;
      end_sync <= 1'b0;
      end_prev <= 1'b0;
      err_meta <= 1'b0;
      err_sync <= 1'b0;
    end else begin
      end_meta <= end_uut;
      end_sync <= end_meta;
      end_prev <= end_sync;
      err_meta <= err_uut;
      err_sync <= err_meta;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state          <= autotest_pkg::SEQ_IDLE;
      rst_uut        <= 1'b1;
      hold_cnt       <= '0;
      timer          <= '0;
      cur_last       <= 1'b0;
      result_valid   <= 1'b0;
      result_err     <= 1'b0;
      result_timeout <= 1'b0;
      result_index   <= '0;
      done           <= 1'b0;
    end else begin
      case (state)
        autotest_pkg::SEQ_IDLE, autotest_pkg::SEQ_FINISHED: begin
          if (start) begin
            done  <= 1'b0;
            state <= autotest_pkg::SEQ_FETCH;
          end
        end
        autotest_pkg::SEQ_FETCH: begin
          if (in.valid) begin
            cur_last <= in.last;
            hold_cnt <= '0;
            state    <= autotest_pkg::SEQ_RESET_HOLD;
          end else if (no_records) begin
            done  <= 1'b1;
            state <= autotest_pkg::SEQ_FINISHED;
          end
        end
        autotest_pkg::SEQ_RESET_HOLD: begin
          // operand settles under reset for 4 clocks
          if (hold_cnt == 2'd3) begin
            rst_uut <= 1'b0;
            timer   <= '0;
            state   <= autotest_pkg::SEQ_RUN;
          end else begin
            hold_cnt <= hold_cnt + 1'b1;
          end
        end
        autotest_pkg::SEQ_RUN: begin
          if (run_end) begin
            rst_uut        <= 1'b1;
            result_valid   <= 1'b1;
            result_index   <= cur_index;
            result_err     <= end_rise && err_sync;
            result_timeout <= !end_rise;
            state          <= autotest_pkg::SEQ_REPORT;
          end else begin
            timer <= timer + 1'b1;
          end
        end
        autotest_pkg::SEQ_REPORT: begin
          result_valid <= 1'b0;
          if (cur_last) begin
            done  <= 1'b1;
            state <= autotest_pkg::SEQ_FINISHED;
          end else begin
            state <= autotest_pkg::SEQ_FETCH;
          end
        end
        default: state <= autotest_pkg::SEQ_IDLE;
      endcase
    end
  end

  // operand and captured output
  always_ff @(posedge clk) begin
    if (in.valid && in.ready) begin
      input_to_uut <= in.data;
      cur_index    <= in.index;
    end
    if (run_end) begin
      result_data <= output_from_uut;
    end
  end

endmodule : uut_sequencer

/* design/uut_clock_gen.sv */
/* makes the UUT clock by dividing the system clock by 2, 4, 8 or 16;
   a new select takes effect only when the divider wraps */
`timescale 1ns/1ps

module uut_clock_gen (
  input  logic                   clk,
  input  logic                   rst_n,
  input  autotest_pkg::clk_sel_t clk_sel,
  output logic                   clk_uut
);

  logic [3:0]             cnt;
  logic [3:0]             cnt_nxt;
  autotest_pkg::clk_sel_t sel_q;
  autotest_pkg::clk_sel_t sel_nxt;

  assign cnt_nxt = cnt + 1'b1;
  // all counter bits are low right after the wrap
  assign sel_nxt = (cnt == 4'hf) ? clk_sel : sel_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt     <= '0;
      sel_q   <= '0;
      clk_uut <= 1'b0;
    end else begin
      cnt     <= cnt_nxt;
      sel_q   <= sel_nxt;
      // registered so the mux never shows a glitch
      clk_uut <= cnt_nxt[sel_nxt];
    end
  end

endmodule : uut_clock_gen

/* design/autotest_top.sv */
/* self-test harness top: SPI reader feeds the vector FIFO, the sequencer
   drives the UUT on its divided clock and reports each result */
`timescale 1ns/1ps

module autotest_top (
  input  logic                     clk,
  input  logic                     rst_n,
  output logic                     cs,
  output logic                     sclk,
  output logic                     mosi,
  input  logic                     miso,
  output logic                     clk_uut,
  output logic                     rst_uut,
  output autotest_pkg::operand_t   input_to_uut,
  input  autotest_pkg::operand_t   output_from_uut,
  input  logic                     end_uut,
  input  logic                     err_uut,
  input  logic                     start,
  input  autotest_pkg::clk_sel_t   clk_sel,
  output logic                     result_valid,
  output autotest_pkg::operand_t   result_data,
  output logic                     result_err,
  output logic                     result_timeout,
  output autotest_pkg::rec_index_t result_index,
  output logic                     done
);

  // set when the memory holds an empty vector set
  logic no_records;

  vec_stream_if rd2fifo ();
  vec_stream_if fifo2seq ();

  spi_vector_reader u_reader (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .miso       (miso),
    .cs         (cs),
    .sclk       (sclk),
    .mosi       (mosi),
    .no_records (no_records),
    .out        (rd2fifo.src)
  );

  vector_fifo u_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .in    (rd2fifo.dst),
    .out   (fifo2seq.src)
  );

  uut_sequencer u_seq (
    .clk             (clk),
    .rst_n           (rst_n),
    .start           (start),
    .no_records      (no_records),
    .end_uut         (end_uut),
    .err_uut         (err_uut),
    .output_from_uut (output_from_uut),
    .in              (fifo2seq.dst),
    .rst_uut         (rst_uut),
    .input_to_uut    (input_to_uut),
    .result_valid    (result_valid),
    .result_data     (result_data),
    .result_err      (result_err),
    .result_timeout  (result_timeout),
    .result_index    (result_index),
    .done            (done)
  );

  uut_clock_gen u_clk_gen (
    .clk     (clk),
    .rst_n   (rst_n),
    .clk_sel (clk_sel),
    .clk_uut (clk_uut)
  );

endmodule : autotest_top

/* test/spi_mem_model.sv */
/* serial flash model for the harness testbench: answers a 0x03 read with
   continuous bytes from its array, SPI mode 0 */
`timescale 1ns/1ps

module spi_mem_model #(
  parameter int DEPTH = 1024
) (
  input  logic cs,
  input  logic sclk,
  input  logic mosi,
  output logic miso
);

  logic [7:0]  mem [DEPTH];
  logic [31:0] cmd_sr;
  int          rx_bits;
  int          tx_bits;
  int          byte_addr;

  initial begin
    miso    = 1'b0;
    cmd_sr  = '0;
    rx_bits = 0;
    tx_bits = 0;
    // fill mixes every address bit
    for (int a = 0; a < DEPTH; a++) begin
      mem[a] = 8'(a ^ (a >> 8) ^ 8'h5c);
    end
  end

  // command and address in, then count data bits sent
  always @(posedge sclk or posedge cs) begin
    if (cs) begin
      rx_bits <= 0;
      tx_bits <= 0;
    end else if (rx_bits < 32) begin
      cmd_sr  <= {cmd_sr[30:0], mosi};
      rx_bits <= rx_bits + 1;
    end else begin
      tx_bits <= tx_bits + 1;
    end
  end

  assign byte_addr = (int'(cmd_sr[23:0]) + tx_bits / 8) % DEPTH;

  // next data bit goes out on the falling edge, MSB first
  always @(negedge sclk) begin
    if (!cs && rx_bits == 32) begin
      if (cmd_sr[31:24] == 8'h03) begin
        miso <= mem[byte_addr][7 - (tx_bits % 8)];
      end else begin
        miso <= 1'b0;
      end
    end
  end

endmodule : spi_mem_model

/* test/autotest_sva.sv */
/* assertions on the harness SPI pins, the reader stream and the result
   outputs; attached to autotest_top with bind */
`timescale 1ns/1ps

module autotest_sva (
  input logic clk,
  input logic rst_n,
  input logic cs,
  input logic sclk,
  input logic rd_valid,
  input logic rd_ready,
  input logic result_valid,
  input logic done
);

  // mode 0 idle level outside a transaction
  a_sclk_idle: assert property (@(posedge clk) disable iff (!rst_n) cs |-> !sclk)
    else $error("sclk high while cs is high");

  a_rd_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rd_valid && !rd_ready |=> rd_valid)
    else $error("reader valid dropped before ready");

  a_result_not_done: assert property (@(posedge clk) disable iff (!rst_n)
    !(result_valid && done))
    else $error("result_valid high while done is high");

endmodule : autotest_sva

bind autotest_top autotest_sva u_sva (
  .clk          (clk),
  .rst_n        (rst_n),
  .cs           (cs),
  .sclk         (sclk),
  .rd_valid     (rd2fifo.valid),
  .rd_ready     (rd2fifo.ready),
  .result_valid (result_valid),
  .done         (done)
);

/* test/autotest_tb.sv */
/* testbench for the self-test harness: loads records from the vectors file,
   serves them from a flash model, models the UUT and checks every result */
`timescale 1ns/1ps

module autotest_tb;

  logic clk;
  logic rst_n;
  logic cs;
  logic sclk;
  logic mosi;
  logic miso;
  logic clk_uut;
  logic rst_uut;
  logic end_uut;
  logic err_uut;
  logic start;
  logic result_valid;
  logic result_err;
  logic result_timeout;
  logic done;
  autotest_pkg::operand_t   input_to_uut;
  autotest_pkg::operand_t   output_from_uut;
  autotest_pkg::operand_t   result_data;
  autotest_pkg::rec_index_t result_index;
  autotest_pkg::clk_sel_t   clk_sel;

  autotest_pkg::operand_t vec_op  [$];
  autotest_pkg::operand_t vec_exp [$];
  int vec_sel [$];
  int vec_err [$];
  int cyc = 0;
  int uut_latency = 4;
  int uut_cycles;
  bit fifo_backpressure;

  spi_mem_model u_mem (.cs(cs), .sclk(sclk), .mosi(mosi), .miso(miso));

  autotest_top UUT (
    .clk(clk), .rst_n(rst_n), .cs(cs), .sclk(sclk), .mosi(mosi), .miso(miso),
    .clk_uut(clk_uut), .rst_uut(rst_uut), .input_to_uut(input_to_uut),
    .output_from_uut(output_from_uut), .end_uut(end_uut), .err_uut(err_uut),
    .start(start), .clk_sel(clk_sel), .result_valid(result_valid),
    .result_data(result_data), .result_err(result_err),
    .result_timeout(result_timeout), .result_index(result_index), .done(done)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // reader held off by a full FIFO
  always @(negedge clk) begin
    if (UUT.rd2fifo.valid && !UUT.rd2fifo.ready) fifo_backpressure = 1'b1;
  end

  // behavioural UUT finishes uut_latency cycles after reset release
  initial begin
    end_uut = 1'b0;
    err_uut = 1'b0;
    output_from_uut = '0;
    uut_cycles = 0;
  end

  always @(posedge clk_uut or posedge rst_uut) begin
    if (rst_uut) begin
      uut_cycles      <= 0;
      end_uut         <= 1'b0;
      err_uut         <= 1'b0;
      output_from_uut <= '0;
    end else if (!end_uut) begin
      uut_cycles <= uut_cycles + 1;
      if (uut_cycles == uut_latency - 1 && input_to_uut != 32'hdead0000) begin
        output_from_uut <= {input_to_uut[23:0], input_to_uut[31:24]} ^ 32'h5a5a5a5a;
        err_uut         <= (input_to_uut[31:24] == 8'hee);
        end_uut         <= 1'b1;
      end
    end
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_operand(input autotest_pkg::operand_t got,
                               input autotest_pkg::operand_t exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                  $time, what, got, exp));
    end
  endtask

  task automatic check_index(input autotest_pkg::rec_index_t got,
                             input autotest_pkg::rec_index_t exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED at %0t: %s is %0d, expected %0d",
                                  $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input bit got, input bit exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                                  $time, what, got, exp));
    end
  endtask

  task automatic read_vectors();
    int fd;
    int f_sel;
    int f_err;
    autotest_pkg::operand_t f_op;
    autotest_pkg::operand_t f_exp;
    string line;
    fd = $fopen("test/autotest_vectors.txt", "r");
    if (fd == 0) stop_with_failure("cannot open test/autotest_vectors.txt");
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 0 && line.getc(0) != "#") begin
        if ($sscanf(line, "%h %h %h %h", f_sel, f_op, f_exp, f_err) == 4) begin
          vec_sel.push_back(f_sel);
          vec_op.push_back(f_op);
          vec_exp.push_back(f_exp);
          vec_err.push_back(f_err);
        end
      end
    end
    $fclose(fd);
    if (vec_op.size() == 0) stop_with_failure("vectors file holds no records");
  endtask

  // count byte, then each operand MSB first
  task automatic load_image(input int first, input int n);
    u_mem.mem[0] = 8'(n);
    for (int r = 0; r < n; r++) begin
      for (int b = 0; b < 4; b++) begin
        u_mem.mem[1 + 4 * r + b] = vec_op[first + r][31 - 8 * b -: 8];
      end
    end
  endtask

  task automatic wait_uut_rise(output int at_cycle);
    int waited;
    logic prev;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    prev   = 1'b1;
    while (!seen) begin
      @(negedge clk);
      seen = clk_uut && !prev;
      prev = clk_uut;
      waited++;
      if (waited > 40) stop_with_failure("timeout: clk_uut shows no rising edge");
    end
    at_cycle = cyc;
  endtask

  task automatic run_set(input int first, input int n, input int latency);
    int got;
    int waited;
    int k;
    bit finished;
    bit released;
    autotest_pkg::operand_t applied;
    uut_latency = latency;
    load_image(first, n);
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    got      = 0;
    waited   = 0;
    finished = 1'b0;
    released = 1'b0;
    applied  = input_to_uut;
    while (!finished) begin
      @(negedge clk);
      // a new operand only goes out while the UUT is held in reset
      if (input_to_uut !== applied) begin
        check_flag(rst_uut, 1'b1, "rst_uut when a new operand is applied");
        applied = input_to_uut;
      end
      if (!rst_uut) released = 1'b1;
      if (result_valid) begin
        if (got >= n) stop_with_failure("more results than records in the set");
        k = first + got;
        check_index(result_index, autotest_pkg::rec_index_t'(got), "result_index");
        check_operand(result_data, vec_exp[k], "result_data");
        check_operand(input_to_uut, vec_op[k], "input_to_uut");
        check_flag(released, 1'b1, "rst_uut released before the result");
        check_flag(result_err, vec_err[k] != 0, "result_err");
        check_flag(result_timeout, vec_op[k] == 32'hdead0000, "result_timeout");
        released = 1'b0;
        got++;
      end
      finished = done;
      waited++;
      if (waited > 500 * (n + 1) + 1000) stop_with_failure("timeout: done never rose");
    end
    check_index(autotest_pkg::rec_index_t'(got), autotest_pkg::rec_index_t'(n),
                "results before done");
    check_flag(cs, 1'b1, "cs after done");
  endtask

  initial begin
    int t0;
    int t1;
    rst_n   = 1'b0;
    start   = 1'b0;
    clk_sel = '0;
    read_vectors();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // one record per run, each on its own UUT clock
    for (int i = 0; i < vec_op.size(); i++) begin
      @(posedge clk);
      clk_sel <= autotest_pkg::clk_sel_t'(vec_sel[i]);
      // new select lands at the next 16-cycle wrap
      repeat (20) @(posedge clk);
      wait_uut_rise(t0);
      wait_uut_rise(t1);
      check_flag((t1 - t0) == (2 << vec_sel[i]), 1'b1,
                 $sformatf("clk_uut period of %0d cycles for select %0d", t1 - t0, vec_sel[i]));
      run_set(i, 1, 4);
    end

    // empty vector set
    run_set(0, 0, 4);

    // slow UUT backs the FIFO up, then the same set again
    @(posedge clk);
    clk_sel <= 2'd3;
    repeat (20) @(posedge clk);
    for (int pass = 0; pass < 2; pass++) begin
      fifo_backpressure = 1'b0;
      run_set(0, vec_op.size(), 15);
      check_flag(fifo_backpressure, 1'b1, "FIFO full during slow run");
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule : autotest_tb

/* test/autotest_vectors.txt */
# one record per line, all hex: clock select, operand, expected UUT output, expected error
# operand dead0000 never finishes, so its expected output stays at the UUT reset value
0 12345678 6e0c2248 0
1 ee001122 5a4b78b4 1
2 dead0000 00000000 0
3 a5a5a5a5 ffffffff 0
0 00000000 5a5a5a5a 0
1 eeffffff a5a5a5b4 1
2 0f1e2d3c 44776655 0
3 80000001 5a5a5bda 0
1 cafef00d a4aa5790 0
0 7e000000 5a5a5a24 0
2 ee0000ff 5a5aa5b4 1
3 13579bdf 0dc18549 0
0 01020304 58595e5b 0
1 ffff0000 a55a5aa5 0

/* compile.f */
+incdir+design
design/autotest_pkg.sv
design/vec_stream_if.sv
design/spi_vector_reader.sv
design/vector_fifo.sv
design/uut_sequencer.sv
design/uut_clock_gen.sv
design/autotest_top.sv
test/spi_mem_model.sv
test/autotest_sva.sv
test/autotest_tb.sv
